// ==== crate_bridge_settings.svh ====
`ifndef CRATE_BRIDGE_SETTINGS_SVH
`define CRATE_BRIDGE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Crate register bridge sizing
////////////////////////////////////////////////////////////

// Number of TURFIO links behind the bridge
`define CRATE_NUM_LINKS 4

// Crate address and register data widths
`define CRATE_ADDR_W 27
`define CRATE_DATA_W 32

// ps_clk cycles a lane waits for its link to answer
`define CRATE_TIMEOUT_CYCLES 64

`endif

// ==== crate_bridge_pkg.sv ====
`include "crate_bridge_settings.svh"

package crate_bridge_pkg;

    ////////////////////////////////////////////////////////////
    // Payload types shared by router, lanes and arbiter
    ////////////////////////////////////////////////////////////

    // Selects one TURFIO link
    typedef logic [$clog2(`CRATE_NUM_LINKS)-1:0] link_idx_t;

    // Register address inside one crate
    typedef logic [`CRATE_ADDR_W-1:0] crate_addr_t;

    // Register read and write data
    typedef logic [`CRATE_DATA_W-1:0] crate_data_t;

    // Outcome of one access, returned with every response
    // Invalid means the link was down and nothing was issued
    typedef enum logic [1:0] {
        RESP_OK      = 2'd0,
        RESP_TIMEOUT = 2'd1,
        RESP_INVALID = 2'd2
    } resp_status_e;

endpackage

// ==== crate_cmd_router.sv ====
`include "crate_bridge_settings.svh"

module crate_cmd_router (
    input  logic                          ps_clk,
    input  logic                          arst_n_i,
    // Request from the processing system side
    input  logic                          req_valid_i,
    input  crate_bridge_pkg::link_idx_t   req_link_i,
    input  crate_bridge_pkg::crate_addr_t req_addr_i,
    input  crate_bridge_pkg::crate_data_t req_wdata_i,
    input  logic                          req_we_i,
    output logic                          req_ready_o,
    // Link status and flag clear
    input  logic [`CRATE_NUM_LINKS-1:0]   link_up_i,
    input  logic                          flags_clear_i,
    // Dispatch to the lanes
    output logic [`CRATE_NUM_LINKS-1:0]   lane_valid_o,
    input  logic [`CRATE_NUM_LINKS-1:0]   lane_ready_i,
    output crate_bridge_pkg::crate_addr_t lane_addr_o,
    output crate_bridge_pkg::crate_data_t lane_wdata_o,
    output logic                          lane_we_o,
    // Rejects toward the response arbiter
    output logic                          reject_valid_o,
    input  logic                          reject_ready_i,
    output crate_bridge_pkg::link_idx_t   reject_link_o,
    // Sticky invalid-access flags
    output logic [`CRATE_NUM_LINKS-1:0]   invalid_o
);
    import crate_bridge_pkg::*;

    logic [`CRATE_NUM_LINKS-1:0] link_sel;
    logic                        target_up;
    logic                        target_idle;
    logic                        reject_take;

    // One-hot decode of the requested link
    always_comb begin
        for (int k = 0; k < `CRATE_NUM_LINKS; k++) begin
            link_sel[k] = (req_link_i == link_idx_t'(k));
        end
    end

    assign target_up   = |(link_sel & link_up_i);
    assign target_idle = |(link_sel & lane_ready_i);

    // A pending reject blocks everything, a busy lane only blocks its own link
    assign req_ready_o = !reject_valid_o && (target_up ? target_idle : 1'b1);

    // Up links go straight to their lane, which registers the command
    assign lane_valid_o = link_sel & {`CRATE_NUM_LINKS{req_valid_i && target_up && !reject_valid_o}};
    assign lane_addr_o  = req_addr_i;
    assign lane_wdata_o = req_wdata_i;
    assign lane_we_o    = req_we_i;

    assign reject_take = req_valid_i && req_ready_o && !target_up;

    ////////////////////////////////////////////////////////////
    // Reject register and invalid flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reject_valid_o <= 1'b0;
            invalid_o      <= '0;
        end else begin
            if (reject_take) begin
                reject_valid_o <= 1'b1;
            end else if (reject_ready_i) begin
                reject_valid_o <= 1'b0;
            end
            // New invalid access wins over a clear on the same edge
            invalid_o <= (flags_clear_i ? '0 : invalid_o)
                       | (reject_take ? link_sel : '0);
        end
    end

    always_ff @(posedge ps_clk) begin
        if (reject_take) begin
            reject_link_o <= req_link_i;
        end
    end

endmodule

// ==== turfio_link_lane.sv ====
`include "crate_bridge_settings.svh"

module turfio_link_lane #(
    parameter int TIMEOUT_CYCLES = `CRATE_TIMEOUT_CYCLES
) (
    input  logic                           ps_clk,
    input  logic                           arst_n_i,
    // Command from the router
    input  logic                           cmd_valid_i,
    input  crate_bridge_pkg::crate_addr_t  cmd_addr_i,
    input  crate_bridge_pkg::crate_data_t  cmd_wdata_i,
    input  logic                           cmd_we_i,
    output logic                           cmd_ready_o,
    input  logic                           flags_clear_i,
    // TURFIO link command port
    output logic                           link_cmd_valid_o,
    input  logic                           link_cmd_ready_i,
    output crate_bridge_pkg::crate_addr_t  link_cmd_addr_o,
    output crate_bridge_pkg::crate_data_t  link_cmd_wdata_o,
    output logic                           link_cmd_we_o,
    // TURFIO link response port
    input  logic                           link_resp_valid_i,
    input  crate_bridge_pkg::crate_data_t  link_resp_rdata_i,
    output logic                           link_resp_ready_o,
    // Response toward the arbiter
    output logic                           resp_valid_o,
    input  logic                           resp_ready_i,
    output crate_bridge_pkg::resp_status_e resp_status_o,
    output crate_bridge_pkg::crate_data_t  resp_rdata_o,
    // Sticky timeout flag
    output logic                           timeout_o
);
    import crate_bridge_pkg::*;

    localparam int CNT_W = (TIMEOUT_CYCLES > 1) ? $clog2(TIMEOUT_CYCLES) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_RESP
    } lane_state_e;

    lane_state_e      state_q;
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_expired;

    crate_addr_t      cmd_addr_q;
    crate_data_t      cmd_wdata_q;
    logic             cmd_we_q;
    resp_status_e     resp_status_q;
    crate_data_t      resp_rdata_q;

    assign wait_expired = (wait_cnt == '0);

    assign cmd_ready_o       = (state_q == ST_IDLE);
    assign link_cmd_valid_o  = (state_q == ST_ISSUE);
    assign resp_valid_o      = (state_q == ST_RESP);

    // Responses outside the wait state are simply dropped
    assign link_resp_ready_o = 1'b1;

    assign link_cmd_addr_o  = cmd_addr_q;
    assign link_cmd_wdata_o = cmd_wdata_q;
    assign link_cmd_we_o    = cmd_we_q;
    assign resp_status_o    = resp_status_q;
    assign resp_rdata_o     = resp_rdata_q;

    ////////////////////////////////////////////////////////////
    // Lane FSM, timeout counter and flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            wait_cnt  <= '0;
            timeout_o <= 1'b0;
        end else begin
            if (flags_clear_i) begin
                timeout_o <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (cmd_valid_i) begin
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    // Count starts once the link has taken the command
                    if (link_cmd_ready_i) begin
                        state_q  <= ST_WAIT;
                        wait_cnt <= CNT_W'(TIMEOUT_CYCLES - 1);
                    end
                end
                ST_WAIT: begin
                    if (link_resp_valid_i) begin
                        state_q <= ST_RESP;
                    end else if (wait_expired) begin
                        state_q   <= ST_RESP;
                        timeout_o <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                default: begin
                    if (resp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Command and response payload
    always_ff @(posedge ps_clk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_addr_q  <= cmd_addr_i;
            cmd_wdata_q <= cmd_wdata_i;
            cmd_we_q    <= cmd_we_i;
        end
        if (state_q == ST_WAIT) begin
            if (link_resp_valid_i) begin
                resp_status_q <= RESP_OK;
                resp_rdata_q  <= link_resp_rdata_i;
            end else if (wait_expired) begin
                resp_status_q <= RESP_TIMEOUT;
                resp_rdata_q  <= '0;
            end
        end
    end

endmodule

// ==== crate_resp_arbiter.sv ====
`include "crate_bridge_settings.svh"

module crate_resp_arbiter (
    input  logic                           ps_clk,
    input  logic                           arst_n_i,
    // Lane responses
    input  logic [`CRATE_NUM_LINKS-1:0]    lane_valid_i,
    input  crate_bridge_pkg::resp_status_e lane_status_i [`CRATE_NUM_LINKS],
    input  crate_bridge_pkg::crate_data_t  lane_rdata_i [`CRATE_NUM_LINKS],
    output logic [`CRATE_NUM_LINKS-1:0]    lane_ready_o,
    // Rejects from the router
    input  logic                           reject_valid_i,
    input  crate_bridge_pkg::link_idx_t    reject_link_i,
    output logic                           reject_ready_o,
    // Merged response stream
    output logic                           resp_valid_o,
    input  logic                           resp_ready_i,
    output crate_bridge_pkg::link_idx_t    resp_link_o,
    output crate_bridge_pkg::resp_status_e resp_status_o,
    output crate_bridge_pkg::crate_data_t  resp_rdata_o
);
    import crate_bridge_pkg::*;

    // Sources 0 to N-1 are the lanes, the last one is the reject
    localparam int NUM_SRC = `CRATE_NUM_LINKS + 1;
    localparam int SRC_W   = $clog2(NUM_SRC);
    localparam int REJ_SRC = `CRATE_NUM_LINKS;

    logic [NUM_SRC-1:0] src_valid;
    logic [SRC_W-1:0]   rr_ptr;
    logic [SRC_W-1:0]   pick;
    logic               pick_found;
    logic               out_free;
    logic               grant_en;
    logic [NUM_SRC-1:0] grant;

    assign src_valid = {reject_valid_i, lane_valid_i};

    // Output register can load when empty or draining this cycle
    assign out_free = !resp_valid_o || resp_ready_i;

    // First valid source at or after the rotating pointer
    always_comb begin : rr_search
        int idx;
        pick_found = 1'b0;
        pick       = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_SRC;
            if (!pick_found && src_valid[idx]) begin
                pick_found = 1'b1;
                pick       = SRC_W'(idx);
            end
        end
    end

    assign grant_en = out_free && pick_found;
    assign grant    = grant_en ? (NUM_SRC'(1) << pick) : '0;

    assign lane_ready_o   = grant[`CRATE_NUM_LINKS-1:0];
    assign reject_ready_o = grant[REJ_SRC];

    ////////////////////////////////////////////////////////////
    // Output register and priority pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_o  <= 1'b0;
            rr_ptr        <= '0;
            resp_link_o   <= '0;
            resp_status_o <= RESP_OK;
            resp_rdata_o  <= '0;
        end else if (grant_en) begin
            resp_valid_o <= 1'b1;
            // Winner drops to lowest priority next round
            rr_ptr <= (pick == SRC_W'(NUM_SRC - 1)) ? '0 : pick + 1'b1;
            if (pick == SRC_W'(REJ_SRC)) begin
                resp_link_o   <= reject_link_i;
                resp_status_o <= RESP_INVALID;
                resp_rdata_o  <= '0;
            end else begin
                resp_link_o   <= link_idx_t'(pick);
                resp_status_o <= lane_status_i[link_idx_t'(pick)];
                resp_rdata_o  <= lane_rdata_i[link_idx_t'(pick)];
            end
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

endmodule

// ==== turf_crate_bridge.sv ====
`include "crate_bridge_settings.svh"

module turf_crate_bridge (
    input  logic                           ps_clk,
    input  logic                           arst_n_i,
    // Register requests
    input  logic                           req_valid_i,
    input  crate_bridge_pkg::link_idx_t    req_link_i,
    input  crate_bridge_pkg::crate_addr_t  req_addr_i,
    input  crate_bridge_pkg::crate_data_t  req_wdata_i,
    input  logic                           req_we_i,
    output logic                           req_ready_o,
    // TURFIO link command ports
    output logic [`CRATE_NUM_LINKS-1:0]    link_cmd_valid_o,
    input  logic [`CRATE_NUM_LINKS-1:0]    link_cmd_ready_i,
    output crate_bridge_pkg::crate_addr_t  link_cmd_addr_o [`CRATE_NUM_LINKS],
    output crate_bridge_pkg::crate_data_t  link_cmd_wdata_o [`CRATE_NUM_LINKS],
    output logic [`CRATE_NUM_LINKS-1:0]    link_cmd_we_o,
    // TURFIO link response ports
    input  logic [`CRATE_NUM_LINKS-1:0]    link_resp_valid_i,
    input  crate_bridge_pkg::crate_data_t  link_resp_rdata_i [`CRATE_NUM_LINKS],
    output logic [`CRATE_NUM_LINKS-1:0]    link_resp_ready_o,
    // Merged responses
    output logic                           resp_valid_o,
    input  logic                           resp_ready_i,
    output crate_bridge_pkg::link_idx_t    resp_link_o,
    output crate_bridge_pkg::resp_status_e resp_status_o,
    output crate_bridge_pkg::crate_data_t  resp_rdata_o,
    // Link status and sticky flags
    input  logic [`CRATE_NUM_LINKS-1:0]    link_up_i,
    input  logic                           flags_clear_i,
    output logic [`CRATE_NUM_LINKS-1:0]    timeout_o,
    output logic [`CRATE_NUM_LINKS-1:0]    invalid_o
);
    import crate_bridge_pkg::*;

    // Router to lanes
    logic [`CRATE_NUM_LINKS-1:0] lane_cmd_valid;
    logic [`CRATE_NUM_LINKS-1:0] lane_cmd_ready;
    crate_addr_t                 lane_cmd_addr;
    crate_data_t                 lane_cmd_wdata;
    logic                        lane_cmd_we;

    // Router to arbiter
    logic                        reject_valid;
    logic                        reject_ready;
    link_idx_t                   reject_link;

    // Lanes to arbiter
    logic [`CRATE_NUM_LINKS-1:0] lane_resp_valid;
    logic [`CRATE_NUM_LINKS-1:0] lane_resp_ready;
    resp_status_e                lane_resp_status [`CRATE_NUM_LINKS];
    crate_data_t                 lane_resp_rdata [`CRATE_NUM_LINKS];

    crate_cmd_router u_router (
        .ps_clk         (ps_clk),
        .arst_n_i       (arst_n_i),
        .req_valid_i    (req_valid_i),
        .req_link_i     (req_link_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_we_i       (req_we_i),
        .req_ready_o    (req_ready_o),
        .link_up_i      (link_up_i),
        .flags_clear_i  (flags_clear_i),
        .lane_valid_o   (lane_cmd_valid),
        .lane_ready_i   (lane_cmd_ready),
        .lane_addr_o    (lane_cmd_addr),
        .lane_wdata_o   (lane_cmd_wdata),
        .lane_we_o      (lane_cmd_we),
        .reject_valid_o (reject_valid),
        .reject_ready_i (reject_ready),
        .reject_link_o  (reject_link),
        .invalid_o      (invalid_o)
    );

    ////////////////////////////////////////////////////////////
    // One lane per TURFIO link
    ////////////////////////////////////////////////////////////

    generate
        for (genvar k = 0; k < `CRATE_NUM_LINKS; k++) begin : gen_lane
            turfio_link_lane #(
                .TIMEOUT_CYCLES(`CRATE_TIMEOUT_CYCLES)
            ) u_lane (
                .ps_clk            (ps_clk),
                .arst_n_i          (arst_n_i),
                .cmd_valid_i       (lane_cmd_valid[k]),
                .cmd_addr_i        (lane_cmd_addr),
                .cmd_wdata_i       (lane_cmd_wdata),
                .cmd_we_i          (lane_cmd_we),
                .cmd_ready_o       (lane_cmd_ready[k]),
                .flags_clear_i     (flags_clear_i),
                .link_cmd_valid_o  (link_cmd_valid_o[k]),
                .link_cmd_ready_i  (link_cmd_ready_i[k]),
                .link_cmd_addr_o   (link_cmd_addr_o[k]),
                .link_cmd_wdata_o  (link_cmd_wdata_o[k]),
                .link_cmd_we_o     (link_cmd_we_o[k]),
                .link_resp_valid_i (link_resp_valid_i[k]),
                .link_resp_rdata_i (link_resp_rdata_i[k]),
                .link_resp_ready_o (link_resp_ready_o[k]),
                .resp_valid_o      (lane_resp_valid[k]),
                .resp_ready_i      (lane_resp_ready[k]),
                .resp_status_o     (lane_resp_status[k]),
                .resp_rdata_o      (lane_resp_rdata[k]),
                .timeout_o         (timeout_o[k])
            );
        end
    endgenerate

    crate_resp_arbiter u_arbiter (
        .ps_clk         (ps_clk),
        .arst_n_i       (arst_n_i),
        .lane_valid_i   (lane_resp_valid),
        .lane_status_i  (lane_resp_status),
        .lane_rdata_i   (lane_resp_rdata),
        .lane_ready_o   (lane_resp_ready),
        .reject_valid_i (reject_valid),
        .reject_link_i  (reject_link),
        .reject_ready_o (reject_ready),
        .resp_valid_o   (resp_valid_o),
        .resp_ready_i   (resp_ready_i),
        .resp_link_o    (resp_link_o),
        .resp_status_o  (resp_status_o),
        .resp_rdata_o   (resp_rdata_o)
    );

endmodule

// ==== turf_crate_bridge_props.sv ====
`include "crate_bridge_settings.svh"

module turf_crate_bridge_props (
    input logic                          ps_clk,
    input logic                          arst_n_i,
    input logic                          resp_valid_i,
    input logic                          resp_ready_i,
    input crate_bridge_pkg::link_idx_t   resp_link_i,
    input logic [1:0]                    resp_status_i,
    input crate_bridge_pkg::crate_data_t resp_rdata_i,
    input logic [`CRATE_NUM_LINKS-1:0]   link_cmd_valid_i,
    input logic [`CRATE_NUM_LINKS-1:0]   link_up_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import crate_bridge_pkg::*;

    // Stalled response keeps its payload
    resp_hold: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_link_i)
            && $stable(resp_status_i) && $stable(resp_rdata_i))
        else $error("response payload changed while stalled");

    resp_status_legal: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
        resp_valid_i |-> resp_status_i inside {RESP_OK, RESP_TIMEOUT, RESP_INVALID})
        else $error("response status outside the legal set");

    for (genvar k = 0; k < `CRATE_NUM_LINKS; k++) begin : gen_link_chk
        cmd_only_when_up: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
            $rose(link_cmd_valid_i[k]) |-> link_up_i[k])
            else $error("command issued on link %0d while it is down", k);
    end

endmodule

bind turf_crate_bridge turf_crate_bridge_props props_i (
    .ps_clk           (ps_clk),
    .arst_n_i         (arst_n_i),
    .resp_valid_i     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .resp_link_i      (resp_link_o),
    .resp_status_i    (resp_status_o),
    .resp_rdata_i     (resp_rdata_o),
    .link_cmd_valid_i (link_cmd_valid_o),
    .link_up_i        (link_up_i)
);

// ==== tb_turf_crate_bridge.sv ====
`include "crate_bridge_settings.svh"

module tb_turf_crate_bridge;
    timeunit 1ns;
    timeprecision 1ps;
    import crate_bridge_pkg::*;

    localparam int N_LINKS   = `CRATE_NUM_LINKS;
    localparam int N_RAND    = 200;
    // Requests over all tests, used to size the watchdog
    localparam int NUM_REQ   = 8 + 2 + 2 + N_RAND;
    localparam int WD_CYCLES = NUM_REQ * 200 + 2000;

    logic               ps_clk = 1'b0;
    logic               arst_n = 1'b0;
    logic               req_valid = 1'b0;
    link_idx_t          req_link = '0;
    crate_addr_t        req_addr = '0;
    crate_data_t        req_wdata = '0;
    logic               req_we = 1'b0;
    logic               req_ready;
    logic [N_LINKS-1:0] link_cmd_valid;
    logic [N_LINKS-1:0] link_cmd_ready = '0;
    crate_addr_t        link_cmd_addr [N_LINKS];
    crate_data_t        link_cmd_wdata [N_LINKS];
    logic [N_LINKS-1:0] link_cmd_we;
    logic [N_LINKS-1:0] link_resp_valid = '0;
    crate_data_t        link_resp_rdata [N_LINKS] = '{default: '0};
    logic [N_LINKS-1:0] link_resp_ready;
    logic               resp_valid;
    logic               resp_ready = 1'b1;
    link_idx_t          resp_link;
    resp_status_e       resp_status;
    crate_data_t        resp_rdata;
    logic [N_LINKS-1:0] link_up = '1;
    logic               flags_clear = 1'b0;
    logic [N_LINKS-1:0] timeout_flags;
    logic [N_LINKS-1:0] invalid_flags;

    // Link model modes
    logic [N_LINKS-1:0] silent = '0;
    logic [N_LINKS-1:0] late = '0;
    logic               rand_ready_en = 1'b0;

    logic [15:0]        lfsr_q = 16'd52750;
    logic [33:0]        exp_q [N_LINKS][$];
    int                 cmd_cnt [N_LINKS] = '{default: 0};
    int                 err_cnt = 0;
    int                 check_cnt = 0;
    int                 resp_cnt = 0;
    int                 test_cnt = 0;
    int                 fail_cnt = 0;
    int                 test_err_base = 0;

    turf_crate_bridge turf_crate_bridge_i (
        .ps_clk            (ps_clk),
        .arst_n_i          (arst_n),
        .req_valid_i       (req_valid),
        .req_link_i        (req_link),
        .req_addr_i        (req_addr),
        .req_wdata_i       (req_wdata),
        .req_we_i          (req_we),
        .req_ready_o       (req_ready),
        .link_cmd_valid_o  (link_cmd_valid),
        .link_cmd_ready_i  (link_cmd_ready),
        .link_cmd_addr_o   (link_cmd_addr),
        .link_cmd_wdata_o  (link_cmd_wdata),
        .link_cmd_we_o     (link_cmd_we),
        .link_resp_valid_i (link_resp_valid),
        .link_resp_rdata_i (link_resp_rdata),
        .link_resp_ready_o (link_resp_ready),
        .resp_valid_o      (resp_valid),
        .resp_ready_i      (resp_ready),
        .resp_link_o       (resp_link),
        .resp_status_o     (resp_status),
        .resp_rdata_o      (resp_rdata),
        .link_up_i         (link_up),
        .flags_clear_i     (flags_clear),
        .timeout_o         (timeout_flags),
        .invalid_o         (invalid_flags)
    );

    initial begin
        forever begin
            #5 ps_clk = ~ps_clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Read data a link returns for an address
    function automatic logic [31:0] read_pattern(input int link, input crate_addr_t addr);
        logic [31:0] key;
        key = 32'hA55A6996;
        for (int i = 0; i < link; i++) begin
            key = {key[30:0], key[31]};
        end
        return {5'b0, addr} ^ key;
    endfunction

    // Status in the top two bits, data below
    function automatic logic [33:0] expected_resp(input int link, input crate_addr_t addr,
                                                  input crate_data_t wdata, input logic we,
                                                  input logic up, input logic no_answer);
        if (!up) begin
            return {RESP_INVALID, 32'h0};
        end else if (no_answer) begin
            return {RESP_TIMEOUT, 32'h0};
        end else if (we) begin
            return {RESP_OK, wdata};
        end
        return {RESP_OK, read_pattern(link, addr)};
    endfunction

    ////////////////////////////////////////////////////////////
    // TURFIO link models
    ////////////////////////////////////////////////////////////

    task automatic run_link(input int k);
        int          d;
        logic [31:0] ans;
        forever begin
            @(negedge ps_clk);
            if (link_cmd_valid[k]) begin
                ans = link_cmd_we[k] ? link_cmd_wdata[k] : read_pattern(k, link_cmd_addr[k]);
                repeat (rand_bits(2)) @(posedge ps_clk);
                @(posedge ps_clk);
                link_cmd_ready[k] <= 1'b1;
                // Command transfers on this edge
                @(posedge ps_clk);
                link_cmd_ready[k] <= 1'b0;
                cmd_cnt[k]++;
                d = late[k] ? 100 : 1 + int'(rand_bits(6)) % 40;
                if (!silent[k]) begin
                    repeat (d - 1) @(posedge ps_clk);
                    link_resp_valid[k] <= 1'b1;
                    link_resp_rdata[k] <= ans;
                    // Lane takes every answer, late ones included
                    @(negedge ps_clk);
                    check_value("link_resp_ready_o", 32'(link_resp_ready[k]), 32'h1);
                    @(posedge ps_clk);
                    link_resp_valid[k] <= 1'b0;
                end
            end
        end
    endtask

    initial begin
        fork
            run_link(0);
            run_link(1);
            run_link(2);
            run_link(3);
        join_none
    end

    // Output back-pressure, random only during the traffic test
    always @(posedge ps_clk) begin
        resp_ready <= rand_ready_en ? (rand_bits(2) != 32'd0) : 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Response checker
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("ERROR %0t %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    task automatic compare_resp();
        logic [33:0] exp;
        int          l;
        l = int'(resp_link);
        resp_cnt++;
        check_cnt++;
        assert (exp_q[l].size() != 0) else begin
            err_cnt++;
            $display("ERROR %0t response on link %0d with no request waiting for it", $time, l);
        end
        if (exp_q[l].size() != 0) begin
            exp = exp_q[l].pop_front();
            check_value("resp_status_o", 32'(resp_status), 32'(exp[33:32]));
            check_value("resp_rdata_o", resp_rdata, exp[31:0]);
        end
    endtask

    // Outputs are settled at the falling edge, transfer follows on the rising edge
    always @(negedge ps_clk) begin
        if (arst_n && resp_valid && resp_ready) begin
            compare_resp();
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge ps_clk);
        $display("Watchdog expired after %0d cycles, responses are missing", WD_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic send_req(input int link, input crate_addr_t addr,
                            input crate_data_t wdata, input logic we);
        @(posedge ps_clk);
        req_valid <= 1'b1;
        req_link  <= link_idx_t'(link);
        req_addr  <= addr;
        req_wdata <= wdata;
        req_we    <= we;
        do begin
            @(negedge ps_clk);
        end while (!req_ready);
        @(posedge ps_clk);
        exp_q[link].push_back(expected_resp(link, addr, wdata, we, link_up[link],
                                            silent[link] | late[link]));
        req_valid <= 1'b0;
    endtask

    task automatic send_random(input int link);
        send_req(link, crate_addr_t'(rand_bits(27)), rand_bits(32), rand_bits(1) != 0);
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int k = 0; k < N_LINKS; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    task automatic wait_drained();
        while (pending() != 0) begin
            @(negedge ps_clk);
        end
        repeat (2) @(posedge ps_clk);
    endtask

    task automatic pulse_clear();
        @(posedge ps_clk);
        flags_clear <= 1'b1;
        @(posedge ps_clk);
        flags_clear <= 1'b0;
        @(negedge ps_clk);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("test %0d %s: pass", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: fail, %0d errors", test_cnt, name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int cmd_base;
        int resp_base;
        repeat (5) @(posedge ps_clk);
        arst_n <= 1'b1;

        // Idle outputs right after reset
        repeat (3) begin
            @(negedge ps_clk);
            check_value("resp_valid_o", 32'(resp_valid), 32'h0);
            check_value("link_cmd_valid_o", 32'(link_cmd_valid), 32'h0);
            check_value("timeout_o", 32'(timeout_flags), 32'h0);
            check_value("invalid_o", 32'(invalid_flags), 32'h0);
        end
        end_test("reset state");

        for (int k = 0; k < N_LINKS; k++) begin
            send_req(k, crate_addr_t'(rand_bits(27)), rand_bits(32), 1'b1);
            send_req(k, crate_addr_t'(rand_bits(27)), rand_bits(32), 1'b0);
        end
        wait_drained();
        end_test("up-link reads and writes");

        // Link 2 down
        @(posedge ps_clk);
        link_up <= 4'b1011;
        cmd_base = cmd_cnt[2];
        send_random(2);
        send_random(2);
        wait_drained();
        @(negedge ps_clk);
        check_value("invalid_o", 32'(invalid_flags), 32'h4);
        check_value("link 2 commands", cmd_cnt[2], cmd_base);
        pulse_clear();
        check_value("invalid_o", 32'(invalid_flags), 32'h0);
        link_up <= 4'b1111;
        end_test("down link reject");

        // Link 1 never answers, link 3 answers too late
        silent <= 4'b0010;
        late   <= 4'b1000;
        send_random(1);
        send_random(3);
        wait_drained();
        @(negedge ps_clk);
        check_value("timeout_o", 32'(timeout_flags), 32'ha);
        // Late answer must be dropped by the lane
        repeat (80) @(posedge ps_clk);
        pulse_clear();
        check_value("timeout_o", 32'(timeout_flags), 32'h0);
        silent <= '0;
        late   <= '0;
        end_test("link timeout");

        resp_base = resp_cnt;
        rand_ready_en <= 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            send_random(int'(rand_bits(2)));
            repeat (rand_bits(2)) @(posedge ps_clk);
        end
        wait_drained();
        rand_ready_en <= 1'b0;
        check_value("response count", resp_cnt - resp_base, N_RAND);
        end_test("random traffic");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== turf_crate_bridge.f ====
+incdir+.
crate_bridge_pkg.sv
crate_cmd_router.sv
turfio_link_lane.sv
crate_resp_arbiter.sv
turf_crate_bridge.sv
turf_crate_bridge_props.sv
tb_turf_crate_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the crate bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_turf_crate_bridge
LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f turf_crate_bridge.f \
    -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
